/* build.f */
+incdir+verilog
verilog/aluPkg.sv
verilog/aluBus.sv
verilog/aluAddSub.sv
verilog/aluShifter.sv
verilog/aluLogicUnit.sv
verilog/aluCompare.sv
verilog/aluDatapath.sv
verilog/aluHandshake.sv
verilog/aluTop.sv
dv/aluTb_checker.sv
dv/aluTb.sv

/* Bender.yml */
package:
  name: alu

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/aluPkg.sv
      - verilog/aluBus.sv
      - verilog/aluAddSub.sv
      - verilog/aluShifter.sv
      - verilog/aluLogicUnit.sv
      - verilog/aluCompare.sv
      - verilog/aluDatapath.sv
      - verilog/aluHandshake.sv
      - verilog/aluTop.sv
  - target: test
    files:
      - dv/aluTb_checker.sv
      - dv/aluTb.sv

/* dv/aluTb.sv */
`timescale 1ns/1ns
`include "alu_settings.svh"

module aluTb;
	import aluPkg::*;

	localparam int Msb = `ALU_DATA_W - 1;
	// Upper bound on the transactions issued by all tests
	localparam int NumTx = 8 * 50 + 4 + 5 * 32 * 2 + 6 * 6 + 16 + 3;
	localparam int CycleLimit = NumTx * 40 + 100;

	logic clk;
	logic rstN;
	logic req;
	logic ack;
	aluOpE opcode;
	aluDataT opA;
	aluDataT opB;
	aluShamtT shamt;
	aluDataT result;
	logic zero;
	logic overflow;

	int cycles = 0;
	int errCount = 0;
	int testStart = 0;
	int passCount = 0;
	int failCount = 0;

	aluOpE arithOps[8] = '{opAdd, opSub, opAnd, opOr, opNor, opXor, opSubu, opAddu};
	aluOpE shiftOps[5] = '{opSll, opSrl, opSra, opSrav, opLui};
	aluOpE cmpOps[6] = '{opBeq, opBne, opBgez, opTeq, opSlt, opSltu};
	// Equal, unequal, negative, zero, and pairs whose signed and unsigned order differ
	aluDataT pairA[6] = '{32'd5, 32'd5, 32'hFFFFFFFD, 32'd0, 32'h80000000, 32'd1};
	aluDataT pairB[6] = '{32'd5, 32'd6, 32'd7, 32'd0, 32'h7FFFFFFF, 32'hFFFFFFFF};

	aluTop dut_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped answering requests", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Returns {result, zero, overflow}
	function automatic logic [Msb+2:0] model(aluOpE op, aluDataT a, aluDataT b, aluShamtT sh);
		aluDataT r;
		logic z;
		logic v;
		int n;
		r = '0;
		z = 1'b0;
		v = 1'b0;
		n = 0;
		case (op)
			opAddu: r = a + b;
			opAdd: begin
				r = a + b;
				v = (a[Msb] == b[Msb]) && (r[Msb] != a[Msb]);
			end
			opSub: begin
				r = a - b;
				v = (a[Msb] != b[Msb]) && (r[Msb] != a[Msb]);
			end
			opSubu: r = a - b;
			opAnd: r = a & b;
			opOr: r = a | b;
			opNor: r = ~(a | b);
			opXor: r = a ^ b;
			opSlt: r = ($signed(a) < $signed(b)) ? 1 : 0;
			opSltu: r = (a < b) ? 1 : 0;
			opBeq: z = (a == b);
			opBne: z = (a != b);
			opBgez: z = ($signed(a) >= 0);
			opTeq: v = (a == b);
			opSll: r = b << sh;
			opSrl: r = b >> sh;
			opSra: r = $signed(b) >>> sh;
			opSrav: r = $signed(b) >>> a[4:0];
			opLui: r = {b[15:0], 16'h0000};
			opMovn: r = (b != 0) ? a : 0;
			opClo: begin
				while (n <= Msb && a[Msb - n]) n++;
				r = n;
			end
			default: r = '0;
		endcase
		return {r, z, v};
	endfunction

	// Immediate checks plus failed protocol assertions
	function automatic int totalErrors();
		return errCount + dut_i.checker_i.failures;
	endfunction

	task automatic checkValue(string name, aluDataT exp, aluDataT act);
		assert (act === exp) else begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkOutputs(logic [Msb+2:0] exp);
		checkValue("result", exp[Msb+2:2], result);
		checkValue("zero", aluDataT'(exp[1]), aluDataT'(zero));
		checkValue("overflow", aluDataT'(exp[0]), aluDataT'(overflow));
	endtask

	// One four-phase transaction, req optionally held after ack
	task automatic runOp(aluOpE op, aluDataT a, aluDataT b, aluShamtT sh, int hold = 0);
		logic [Msb+2:0] exp;
		exp = model(op, a, b, sh);
		@(negedge clk);
		opcode = op;
		opA = a;
		opB = b;
		shamt = sh;
		req = 1'b1;
		do @(negedge clk); while (!ack);
		checkOutputs(exp);
		repeat (hold) begin
			@(negedge clk);
			assert (ack) else begin
				$display("ack dropped at %0t ns while req was still held", $time);
				errCount++;
			end
			checkOutputs(exp);
		end
		req = 1'b0;
		do @(negedge clk); while (ack);
	endtask

	task automatic endTest(string name);
		int errs;
		errs = totalErrors();
		if (errs == testStart) begin
			$display("%s: passed", name);
			passCount++;
		end else begin
			$display("%s: failed with %0d errors", name, errs - testStart);
			failCount++;
		end
		testStart = errs;
	endtask

	initial begin
		aluDataT a;
		aluDataT ones;
		int n;
		void'($urandom(32'h11a5779d));
		clk = 1'b0;
		rstN = 1'b0;
		req = 1'b0;
		opcode = opAddu;
		opA = '0;
		opB = '0;
		shamt = '0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		checkValue("ack", '0, aluDataT'(ack));
		checkOutputs('0);
		endTest("reset values");

		foreach (arithOps[k]) begin
			repeat (50) runOp(arithOps[k], $urandom, $urandom, '0);
		end
		runOp(opAdd, 32'h7FFFFFFF, 32'd1, '0);
		runOp(opAddu, 32'h7FFFFFFF, 32'd1, '0);
		runOp(opSub, 32'h80000000, 32'd1, '0);
		runOp(opSubu, 32'h80000000, 32'd1, '0);
		endTest("arithmetic and logic");

		foreach (shiftOps[k]) begin
			for (int s = 0; s < 32; s++) begin
				a = ($urandom & 32'hFFFFFFE0) | s;
				runOp(shiftOps[k], a, $urandom & 32'h7FFFFFFF, aluShamtT'(s));
				runOp(shiftOps[k], a, $urandom | 32'h80000000, aluShamtT'(s));
			end
		end
		endTest("shifts and LUI");

		foreach (cmpOps[k]) begin
			foreach (pairA[p]) runOp(cmpOps[k], pairA[p], pairB[p], '0);
		end
		endTest("branches, trap and set-less-than");

		ones = '1;
		runOp(opClo, ones, $urandom, '0);
		runOp(opClo, '0, $urandom, '0);
		repeat (10) begin
			n = $urandom_range(0, 32);
			a = ~(ones >> n) | ($urandom & ((ones >> n) >> 1));
			runOp(opClo, a, $urandom, '0);
		end
		runOp(opMovn, $urandom, '0, '0);
		runOp(opMovn, $urandom, '0, '0);
		runOp(opMovn, $urandom, $urandom | 32'd1, '0);
		runOp(opMovn, $urandom, 32'h80000000, '0);
		endTest("CLO and MOVN");

		runOp(opAdd, 32'h7FFFFFFF, 32'd1, '0, $urandom_range(1, 10));
		runOp(aluOpE'(5'd25), $urandom, $urandom, '0);
		runOp(aluOpE'(5'd31), 32'd7, 32'd7, '0);
		// Let the last ack fall be sampled by the protocol assertions
		@(negedge clk);
		endTest("back-pressure and undefined opcode");

		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (totalErrors() == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* dv/aluTb_checker.sv */
`timescale 1ns/1ns

module aluTbChecker (
	input logic            clk,
	input logic            rstN,
	input logic            req,
	input logic            ack,
	input aluPkg::aluOpE   opcode,
	input aluPkg::aluDataT result,
	input logic            zero,
	input logic            overflow
);
	import aluPkg::*;

	int failures = 0;

	// Latch edge, then result edge
	ackRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(req) |=> !ack ##1 ack)
		else begin
			$error("ack did not rise two edges after req rose");
			failures++;
		end

	ackFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(req) |=> $fell(ack))
		else begin
			$error("ack did not fall one edge after req fell");
			failures++;
		end

	// Held req freezes the registered outputs
	resultHold: assert property (@(posedge clk) disable iff (!rstN)
		ack && $past(ack) |-> $stable(result) && $stable(zero) && $stable(overflow))
		else begin
			$error("result or flags changed while ack was high");
			failures++;
		end

	zeroOnlyBranch: assert property (@(posedge clk) disable iff (!rstN)
		ack && zero |-> opcode inside {opBeq, opBne, opBgez})
		else begin
			$error("zero flag set for an operation without a zero flag");
			failures++;
		end

	ovfOnlyArithTrap: assert property (@(posedge clk) disable iff (!rstN)
		ack && overflow |-> opcode inside {opAdd, opSub, opTeq})
		else begin
			$error("overflow flag set for an operation without an overflow flag");
			failures++;
		end

endmodule

bind aluTop aluTbChecker checker_i (
	.clk(clk),
	.rstN(rstN),
	.req(req),
	.ack(ack),
	.opcode(opcode),
	.result(result),
	.zero(zero),
	.overflow(overflow)
);

/* verilog/aluTop.sv */
`timescale 1ns/1ns

module aluTop (
	input  logic             clk,
	input  logic             rstN,
	input  logic             req,
	output logic             ack,
	input  aluPkg::aluOpE    opcode,
	input  aluPkg::aluDataT  opA,
	input  aluPkg::aluDataT  opB,
	input  aluPkg::aluShamtT shamt,
	output aluPkg::aluDataT  result,
	output logic             zero,
	output logic             overflow
);

	aluBus bus_i ();

	aluHandshake ctrl_i (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.ack(ack),
		.opcode(opcode),
		.opA(opA),
		.opB(opB),
		.shamt(shamt),
		.result(result),
		.zero(zero),
		.overflow(overflow),
		.bus(bus_i.ctrl)
	);

	aluDatapath dpath_i (
		.bus(bus_i.dpath)
	);

endmodule

/* verilog/aluHandshake.sv */
`timescale 1ns/1ns

module aluHandshake (
	input  logic             clk,
	input  logic             rstN,
	input  logic             req,
	output logic             ack,
	input  aluPkg::aluOpE    opcode,
	input  aluPkg::aluDataT  opA,
	input  aluPkg::aluDataT  opB,
	input  aluPkg::aluShamtT shamt,
	output aluPkg::aluDataT  result,
	output logic             zero,
	output logic             overflow,
	aluBus.ctrl              bus
);
	import aluPkg::*;

	hsStateE state;
	hsStateE stateNext;
	logic latchOps;
	logic captureRes;

	always_comb begin
		stateNext = state;
		latchOps = 1'b0;
		captureRes = 1'b0;
		case (state)
			hsIdle: begin
				if (req) begin
					stateNext = hsBusy;
					latchOps = 1'b1;
				end
			end
			hsBusy: begin
				stateNext = hsDone;
				captureRes = 1'b1;
			end
			hsDone: begin
				// Requester holding req keeps the results frozen
				if (!req) begin
					stateNext = hsIdle;
				end
			end
			default: stateNext = hsIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= hsIdle;
			ack <= 1'b0;
			result <= '0;
			zero <= 1'b0;
			overflow <= 1'b0;
		end else begin
			state <= stateNext;
			ack <= (stateNext == hsDone);
			if (captureRes) begin
				result <= bus.result;
				zero <= bus.zero;
				overflow <= bus.overflow;
			end
		end
	end

	// Datapath sees only operands captured at the start of a transaction
	always_ff @(posedge clk) begin
		if (latchOps) begin
			bus.op <= opcode;
			bus.a <= opA;
			bus.b <= opB;
			bus.shamt <= shamt;
		end
	end

endmodule

/* verilog/aluDatapath.sv */
`timescale 1ns/1ns

module aluDatapath (
	aluBus.dpath bus
);
	import aluPkg::*;

	logic isSub;
	logic shiftLeft;
	logic shiftArith;
	logic shiftUpper;
	aluShamtT shiftAmount;
	aluDataT sum;
	logic ovf;
	aluDataT shifted;
	aluDataT logicValue;
	aluDataT setLess;
	logic cond;

	assign isSub = bus.op inside {opSub, opSubu};
	assign shiftLeft = (bus.op == opSll);
	assign shiftArith = bus.op inside {opSra, opSrav};
	assign shiftUpper = (bus.op == opLui);

	// SRAV takes its amount from the low bits of A
	assign shiftAmount = (bus.op == opSrav) ? aluShamtT'(bus.a) : bus.shamt;

	aluAddSub addSub_i (.a(bus.a), .b(bus.b), .sub(isSub), .sum(sum), .ovf(ovf));

	aluShifter shifter_i (
		.b(bus.b),
		.amount(shiftAmount),
		.arith(shiftArith),
		.left(shiftLeft),
		.upper(shiftUpper),
		.shifted(shifted)
	);

	aluLogicUnit logic_i (.a(bus.a), .b(bus.b), .op(bus.op), .value(logicValue));

	aluCompare compare_i (.a(bus.a), .b(bus.b), .op(bus.op), .setLess(setLess), .cond(cond));

	always_comb begin
		bus.result = '0;
		bus.zero = 1'b0;
		bus.overflow = 1'b0;
		case (bus.op)
			opAddu,
			opSubu: bus.result = sum;
			opAdd,
			opSub: begin
				bus.result = sum;
				bus.overflow = ovf;
			end
			opAnd, opOr, opNor, opXor, opMovn, opClo: bus.result = logicValue;
			opSll, opSrl, opSra, opSrav, opLui: bus.result = shifted;
			opSlt, opSltu: bus.result = setLess;
			opBeq, opBne, opBgez: bus.zero = cond;
			// Trap request leaves through the overflow flag
			opTeq: bus.overflow = cond;
			default: bus.result = '0;
		endcase
	end

endmodule

/* verilog/aluCompare.sv */
`timescale 1ns/1ns

module aluCompare (
	input  aluPkg::aluDataT a,
	input  aluPkg::aluDataT b,
	input  aluPkg::aluOpE   op,
	output aluPkg::aluDataT setLess,
	output logic            cond
);
	import aluPkg::*;

	localparam int Msb = $bits(aluDataT) - 1;

	logic lessSigned;
	logic lessUnsigned;
	logic equal;

	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;
	assign equal = (a == b);

	always_comb begin
		case (op)
			opSlt:   setLess = aluDataT'(lessSigned);
			opSltu:  setLess = aluDataT'(lessUnsigned);
			default: setLess = '0;
		endcase
	end

	// Branch and trap conditions
	always_comb begin
		case (op)
			opBeq,
			opTeq:   cond = equal;
			opBne:   cond = ~equal;
			opBgez:  cond = ~a[Msb];
			default: cond = 1'b0;
		endcase
	end

endmodule

/* verilog/aluLogicUnit.sv */
`timescale 1ns/1ns

module aluLogicUnit (
	input  aluPkg::aluDataT a,
	input  aluPkg::aluDataT b,
	input  aluPkg::aluOpE   op,
	output aluPkg::aluDataT value
);
	import aluPkg::*;

	localparam int DataW = $bits(aluDataT);
	localparam int CntW = $clog2(DataW + 1);

	logic [CntW-1:0] ones;
	logic run;

	// Leading ones counted while the run from the MSB is unbroken
	always_comb begin
		ones = '0;
		run = 1'b1;
		for (int i = DataW - 1; i >= 0; i--) begin
			run = run & a[i];
			ones = ones + CntW'(run);
		end
	end

	always_comb begin
		case (op)
			opAnd:   value = a & b;
			opOr:    value = a | b;
			opNor:   value = ~(a | b);
			opXor:   value = a ^ b;
			opMovn:  value = (b != '0) ? a : '0;
			opClo:   value = aluDataT'(ones);
			default: value = '0;
		endcase
	end

endmodule

/* verilog/aluShifter.sv */
`timescale 1ns/1ns

module aluShifter (
	input  aluPkg::aluDataT  b,
	input  aluPkg::aluShamtT amount,
	input  logic             arith,
	input  logic             left,
	input  logic             upper,
	output aluPkg::aluDataT  shifted
);
	import aluPkg::*;

	localparam int HalfW = $bits(aluDataT) / 2;

	aluDataT leftVal;
	aluDataT rightVal;
	aluDataT upperVal;

	assign leftVal = b << amount;

	// Right shift fills with the sign bit only when arith is set
	always_comb begin
		if (arith) begin
			rightVal = $signed(b) >>> amount;
		end else begin
			rightVal = b >> amount;
		end
	end

	// LUI places the immediate in the upper half
	assign upperVal = {b[HalfW-1:0], {HalfW{1'b0}}};

	always_comb begin
		if (upper) begin
			shifted = upperVal;
		end else if (left) begin
			shifted = leftVal;
		end else begin
			shifted = rightVal;
		end
	end

endmodule

/* verilog/aluAddSub.sv */
`timescale 1ns/1ns

module aluAddSub (
	input  aluPkg::aluDataT a,
	input  aluPkg::aluDataT b,
	input  logic            sub,
	output aluPkg::aluDataT sum,
	output logic            ovf
);
	import aluPkg::*;

	localparam int Msb = $bits(aluDataT) - 1;

	aluDataT bEff;

	// Two's complement subtract as A + ~B + 1
	assign bEff = sub ? ~b : b;

	always_comb begin
		sum = a + bEff + aluDataT'(sub);
	end

	// Same operand signs but a different sum sign
	always_comb begin
		ovf = (a[Msb] == bEff[Msb]) && (sum[Msb] != a[Msb]);
	end

endmodule

/* verilog/aluBus.sv */
`timescale 1ns/1ns

interface aluBus;
	import aluPkg::*;

	// Latched operation
	aluOpE op;
	aluDataT a;
	aluDataT b;
	aluShamtT shamt;

	// Datapath outputs, combinational from the fields above
	aluDataT result;
	logic zero;
	logic overflow;

	modport ctrl (
		output op, a, b, shamt,
		input result, zero, overflow
	);

	modport dpath (
		input op, a, b, shamt,
		output result, zero, overflow
	);

endinterface

/* verilog/aluPkg.sv */
`include "alu_settings.svh"

package aluPkg;

	typedef logic [`ALU_DATA_W-1:0] aluDataT;
	typedef logic [`ALU_SHAMT_W-1:0] aluShamtT;
	typedef logic [`ALU_OP_W-1:0] aluOpT;

	// Encodings follow the main decoder
	typedef enum aluOpT {
		opAddu = 5'd0,
		opAdd  = 5'd1,
		opSub  = 5'd2,
		opAnd  = 5'd3,
		opBeq  = 5'd4,
		opBne  = 5'd5,
		opSlt  = 5'd6,
		opOr   = 5'd7,
		opNor  = 5'd8,
		opXor  = 5'd9,
		opSubu = 5'd10,
		opSll  = 5'd11,
		opSrl  = 5'd12,
		opBgez = 5'd13,
		opClo  = 5'd14,
		opSrav = 5'd15,
		opSra  = 5'd16,
		opMovn = 5'd17,
		opSltu = 5'd18,
		opLui  = 5'd19,
		opTeq  = 5'd20
	} aluOpE;

	typedef enum logic [1:0] {
		hsIdle,
		hsBusy,
		hsDone
	} hsStateE;

endpackage

/* verilog/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width of the integer datapath
`define ALU_DATA_W 32

// Shift amount as carried by the shamt field
`define ALU_SHAMT_W 5

// Opcode as produced by the instruction decoder
`define ALU_OP_W 5

`endif
